// ==== design/lfa_pkg.sv ====
package lfa_pkg;

   // geometry of the lookahead buffer.
   localparam int lfa_depth = 64;            // entries, a power of two.
   localparam int lfa_aw    = $clog2(lfa_depth);

   // the write side stops once the free entries drop to this many.
   // This leaves room for the write that is already in flight from ingress.
   localparam int lfa_slack = 2;

   typedef logic [31:0] lfa_word_t;

endpackage

// ==== design/fe_record_pkg.sv ====
package fe_record_pkg;

   typedef enum logic {
      tag_literal = 1'b0,
      tag_skip    = 1'b1
   } fe_tag_e;

   typedef struct packed {
      fe_tag_e     tag;
      logic [14:0] rsvd;
      logic [15:0] data;                     // payload sent to the consumer.
   } fe_lit_t;

   typedef struct packed {
      fe_tag_e     tag;
      logic [25:0] rsvd;
      logic [4:0]  count;                    // words discarded after this one.
   } fe_skip_t;

   // one stream word, read either as a literal or as a skip record.
   typedef union packed {
      fe_lit_t  lit;
      fe_skip_t skip;
   } fe_word_u;

endpackage

// ==== design/lfa_wr_if.sv ====
`timescale 1ns/1ps

interface lfa_wr_if;
   import lfa_pkg::*;

   logic      wr;                            // one-cycle write strobe.
   lfa_word_t wdata;
   logic      avail;                         // more than lfa_slack entries free.
   logic      empty;

   modport writer (
      output wr, wdata,
      input  avail, empty
   );

   modport buffer (
      input  wr, wdata,
      output avail, empty
   );

endinterface

// ==== design/lfa_rd_if.sv ====
`timescale 1ns/1ps

interface lfa_rd_if;
   import lfa_pkg::*;

   logic              rd;
   logic [lfa_aw-1:0] raddr;
   logic              rd_avail;              // raddr lies inside the window.
   lfa_word_t         rdata;                 // valid one cycle after a taken read.
   logic              rd_ack;
   logic [lfa_aw-1:0] rd_ack_addr;           // new head, within the window or at the tail.

   modport reader (
      output rd, raddr, rd_ack, rd_ack_addr,
      input  rd_avail, rdata
   );

   modport buffer (
      input  rd, raddr, rd_ack, rd_ack_addr,
      output rd_avail, rdata
   );

endinterface

// ==== design/wb_ingress.sv ====
`timescale 1ns/1ps

module wb_ingress (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  lfa_pkg::lfa_word_t wb_dat_w,
   output logic              wb_ack,
   output logic              wb_err,
   lfa_wr_if.writer          wr_port
);

   logic wr_req;
   logic rd_req;

   // the ack cycle blocks a second ack of the same strobe.
   assign wr_req = wb_cyc && wb_stb && wb_we && wr_port.avail && !wb_ack;
   assign rd_req = wb_cyc && wb_stb && !wb_we && !wb_err;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
         wb_err <= 1'b0;
      end else begin
         wb_ack <= wr_req;
         wb_err <= rd_req;                   // reads are not supported.
      end
   end

   always_ff @(posedge clk) begin
      if (wr_req) begin
         wr_port.wdata <= wb_dat_w;
      end
   end

   // the buffer write lands in the same cycle as the acknowledge.
   assign wr_port.wr = wb_ack;

   a_ack_follows_strobe: assert property (
      @(posedge clk) disable iff (!rst_n)
      wb_ack |-> $past(wb_cyc && wb_stb && wb_we)
   );

endmodule

// ==== design/lfa_fifo.sv ====
`timescale 1ns/1ps

module lfa_fifo (
   input  logic      clk,
   input  logic      rst_n,
   lfa_wr_if.buffer  wr_port,
   lfa_rd_if.buffer  rd_port
);

   import lfa_pkg::*;

   localparam logic [lfa_aw:0] depth_c = (lfa_aw + 1)'(lfa_depth);

   lfa_word_t         mem [lfa_depth];
   logic [lfa_aw-1:0] tail;
   logic [lfa_aw-1:0] head;
   logic              wr_pg;
   logic              rd_pg;
   logic [lfa_aw:0]   used;
   logic [lfa_aw:0]   free;
   logic              full;
   logic              rd_take;

   // true when addr sits between the head and the tail.
   function automatic logic in_window(
      input logic [lfa_aw-1:0] addr,
      input logic [lfa_aw-1:0] h,
      input logic [lfa_aw-1:0] t,
      input logic              same_pg
   );
      logic hit;
      if (same_pg) begin
         hit = (addr >= h) && (addr < t);
      end else begin
         hit = (addr >= h) || (addr < t);   // the window wraps past the top entry.
      end
      return hit;
   endfunction

   // the page bits extend both pointers by one bit, so the distance is a plain difference.
   assign used = {wr_pg, tail} - {rd_pg, head};
   assign free = depth_c - used;
   assign full = (wr_pg != rd_pg) && (tail == head);

   assign wr_port.empty = (wr_pg == rd_pg) && (tail == head);
   assign wr_port.avail = free > lfa_slack;

   assign rd_port.rd_avail = in_window(rd_port.raddr, head, tail, wr_pg == rd_pg);
   assign rd_take = rd_port.rd && rd_port.rd_avail;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tail  <= '0;
         wr_pg <= 1'b0;
         head  <= '0;
         rd_pg <= 1'b0;
      end else begin
         if (wr_port.wr) begin
            tail <= tail + 1'b1;
            if (tail == lfa_aw'(lfa_depth - 1)) begin
               wr_pg <= ~wr_pg;
            end
         end
         if (rd_port.rd_ack) begin
            head <= rd_port.rd_ack_addr;
            // a smaller head means the consumer crossed the top of the array.
            if (rd_port.rd_ack_addr < head) begin
               rd_pg <= ~rd_pg;
            end
         end
      end
   end

   // inferred array with one cycle of read latency.
   always_ff @(posedge clk) begin
      if (wr_port.wr) begin
         mem[tail] <= wr_port.wdata;
      end
      if (rd_take) begin
         rd_port.rdata <= mem[rd_port.raddr];
      end
   end

   a_no_write_when_full: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_port.wr |-> !full
   );

   a_ack_inside_window: assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_port.rd_ack |->
         (in_window(rd_port.rd_ack_addr, head, tail, wr_pg == rd_pg) ||
          (rd_port.rd_ack_addr == tail))
   );

   a_empty_after_full_ack: assert property (
      @(posedge clk) disable iff (!rst_n)
      (rd_port.rd_ack && (rd_port.rd_ack_addr == tail) && !wr_port.wr) |=> wr_port.empty
   );

endmodule

// ==== design/record_parser.sv ====
`timescale 1ns/1ps

module record_parser (
   input  logic        clk,
   input  logic        rst_n,
   lfa_rd_if.reader    rd_port,
   output logic        lit_valid,
   output logic [15:0] lit_data,
   input  logic        lit_ready
);

   import lfa_pkg::*;
   import fe_record_pkg::*;

   typedef enum logic [1:0] {
      st_fetch,
      st_wait,
      st_lit,
      st_skip
   } state_t;

   state_t            state;
   logic [lfa_aw-1:0] rec_addr;              // address of the record in flight.
   logic [4:0]        cnt;
   logic [lfa_aw-1:0] last_addr;
   logic [lfa_aw-1:0] next_addr;
   fe_word_u          word;

   assign word = rd_port.rdata;

   // last word a skip discards, and the record that follows it.
   assign last_addr = rec_addr + lfa_aw'(cnt);
   assign next_addr = (state == st_skip) ? last_addr + 1'b1 : rec_addr + 1'b1;

   assign rd_port.rd    = (state == st_fetch);
   assign rd_port.raddr = (state == st_skip) ? last_addr : rec_addr;

   // the head follows an accepted literal or a confirmed skip span.
   assign rd_port.rd_ack = ((state == st_lit) && lit_ready) ||
                           ((state == st_skip) && rd_port.rd_avail);
   assign rd_port.rd_ack_addr = next_addr;

   assign lit_valid = (state == st_lit);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_fetch;
         rec_addr <= '0;
      end else begin
         case (state)
            st_fetch: if (rd_port.rd_avail) state <= st_wait;
            st_wait: begin
               if (word.lit.tag == tag_literal) begin
                  state <= st_lit;
               end else begin
                  state <= st_skip;
               end
            end
            default: begin
               if (rd_port.rd_ack) begin
                  rec_addr <= next_addr;
                  state    <= st_fetch;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_wait) begin
         lit_data <= word.lit.data;
         cnt      <= word.skip.count;      // only meaningful for a skip record.
      end
   end

   a_lit_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      (lit_valid && !lit_ready) |=> (lit_valid && $stable(lit_data))
   );

endmodule

// ==== design/fe_top.sv ====
`timescale 1ns/1ps

module fe_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               wb_cyc,
   input  logic               wb_stb,
   input  logic               wb_we,
   input  lfa_pkg::lfa_word_t wb_dat_w,
   output logic               wb_ack,
   output logic               wb_err,
   output logic               lit_valid,
   output logic [15:0]        lit_data,
   input  logic               lit_ready,
   output logic               buf_empty
);

   lfa_wr_if wr_if ();
   lfa_rd_if rd_if ();

   wb_ingress u_ingress (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_dat_w (wb_dat_w),
      .wb_ack   (wb_ack),
      .wb_err   (wb_err),
      .wr_port  (wr_if.writer)
   );

   lfa_fifo u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_port (wr_if.buffer),
      .rd_port (rd_if.buffer)
   );

   record_parser u_parser (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_port   (rd_if.reader),
      .lit_valid (lit_valid),
      .lit_data  (lit_data),
      .lit_ready (lit_ready)
   );

   assign buf_empty = wr_if.empty;

endmodule

// ==== testbench/fe_tb.sv ====
`timescale 1ns/1ps

module fe_tb;

   import lfa_pkg::*;

   localparam int stream_words   = 600;
   localparam int timeout_cycles = stream_words * 8 + 2000;
   localparam int held_acks      = lfa_depth - lfa_slack;
   localparam int drain_cycles   = 200;

   typedef logic [15:0] payload_q_t [$];

   logic        clk;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   lfa_word_t   wb_dat_w;
   logic        wb_ack;
   logic        wb_err;
   logic        lit_valid;
   logic [15:0] lit_data;
   logic        lit_ready;
   logic        buf_empty;

   lfa_word_t   stream [$];
   payload_q_t  exp_q;
   logic [31:0] rng = 32'hf8a1_4b0f;
   int          errors = 0;
   int          ack_total = 0;
   int          got = 0;
   int          cycles = 0;
   bit          release_ready = 1'b0;

   fe_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_dat_w  (wb_dat_w),
      .wb_ack    (wb_ack),
      .wb_err    (wb_err),
      .lit_valid (lit_valid),
      .lit_data  (lit_data),
      .lit_ready (lit_ready),
      .buf_empty (buf_empty)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // a literal gives one payload, a skip jumps over itself and count more words.
   function automatic payload_q_t expected_literals(input lfa_word_t words [$]);
      payload_q_t q;
      int         i;
      i = 0;
      while (i < words.size()) begin
         if (words[i][31] == 1'b0) begin
            q.push_back(words[i][15:0]);
            i = i + 1;
         end else begin
            i = i + int'(words[i][4:0]) + 1;
         end
      end
      return q;
   endfunction

   task automatic build_stream();
      lfa_word_t w;
      int        n;
      while (stream.size() < stream_words) begin
         rng = xorshift32(rng);
         w = rng;
         // the first record is a literal so that it pins the head while lit_ready is low.
         if (stream.size() == 0 || rng[7] == 1'b0) begin
            w[31] = 1'b0;
            stream.push_back(w);
         end else begin
            n = int'(rng[2:0]);
            if (n > stream_words - stream.size() - 1) begin
               n = stream_words - stream.size() - 1;
            end
            w[31]  = 1'b1;
            w[4:0] = 5'(n);
            stream.push_back(w);
            repeat (n) begin
               rng = xorshift32(rng);
               stream.push_back(rng);        // filler, it may look like any record.
            end
         end
      end
   endtask

   task automatic write_word(input lfa_word_t data);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_dat_w <= data;
      @(posedge clk);
      while (!wb_ack) @(posedge clk);
   endtask

   task automatic write_stream();
      foreach (stream[i]) begin
         write_word(stream[i]);
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic read_cycle_check();
      int waited;
      waited = 0;
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      @(posedge clk);
      while (!wb_err && waited < 10) begin
         assert (!wb_ack) else begin
            errors++;
            $display("FAIL wb_ack expected %h actual %h", 1'b0, wb_ack);
         end
         @(posedge clk);
         waited++;
      end
      assert (wb_err && !wb_ack) else begin
         errors++;
         $display("the read cycle did not end with an error response");
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      repeat (3) @(posedge clk);
      assert (buf_empty) else begin
         errors++;
         $display("FAIL buf_empty expected %h actual %h", 1'b1, buf_empty);
      end
   endtask

   // with the first literal stuck, the buffer fills up to its slack and then stops.
   task automatic hold_check();
      while (ack_total < held_acks) @(negedge clk);
      repeat (50) @(negedge clk);
      assert (ack_total == held_acks) else begin
         errors++;
         $display("FAIL wb_ack count expected %h actual %h", held_acks, ack_total);
      end
      release_ready = 1'b1;
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      logic [31:0] r;
      lit_ready = 1'b0;
      while (!release_ready) @(posedge clk);
      r = rng;
      forever begin
         r = xorshift32(r);
         lit_ready <= (r[9:8] != 2'b00);     // ready about three cycles in four.
         @(posedge clk);
      end
   end

   always @(posedge clk) begin
      if (rst_n && wb_ack) ack_total++;
      if (rst_n && lit_valid && lit_ready) begin
         assert (got < exp_q.size()) else begin
            errors++;
            $display("literal %h came out after the expected stream had ended", lit_data);
         end
         if (got < exp_q.size()) begin
            assert (lit_data == exp_q[got]) else begin
               errors++;
               $display("FAIL lit_data expected %h actual %h", exp_q[got], lit_data);
            end
         end
         got++;
      end
   end

   initial begin
      while (cycles < timeout_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the stream did not drain within %0d cycles", timeout_cycles);
      $display("error count: %0d", errors);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      int drain;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_dat_w = '0;
      build_stream();
      exp_q = expected_literals(stream);
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (buf_empty) else begin
         errors++;
         $display("FAIL buf_empty expected %h actual %h", 1'b1, buf_empty);
      end
      read_cycle_check();
      fork
         write_stream();
         hold_check();
      join
      while (got < exp_q.size()) @(negedge clk);
      // trailing skip records still retire after the last literal.
      drain = 0;
      while ((!buf_empty || lit_valid) && drain < drain_cycles) begin
         @(negedge clk);
         drain++;
      end
      assert (buf_empty) else begin
         errors++;
         $display("FAIL buf_empty expected %h actual %h", 1'b1, buf_empty);
      end
      assert (!lit_valid) else begin
         errors++;
         $display("FAIL lit_valid expected %h actual %h", 1'b0, lit_valid);
      end
      $display("error count: %0d", errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== src.f ====
design/lfa_pkg.sv
design/fe_record_pkg.sv
design/lfa_wr_if.sv
design/lfa_rd_if.sv
design/wb_ingress.sv
design/lfa_fifo.sv
design/record_parser.sv
design/fe_top.sv
testbench/fe_tb.sv

// ==== Makefile ====
# Verilator build and run of the record front end testbench.

VERILATOR ?= verilator
TOP       ?= fe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Finished with errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
